// ==== filelist.f ====
+incdir+include
hw/odd_pipe_pkg.sv
hw/odd_issue_stage.sv
hw/permute_unit.sv
hw/branch_unit.sv
hw/result_forward_pipe.sv
hw/odd_pipe.sv
verification/odd_pipe_tb.sv

// ==== hw/branch_unit.sv ====
module branch_unit #(
    parameter int LS_ADDR_BITS = 18
) (
    input  logic                                branch_sel,
    input  logic                                permute_sel,
    input  logic                                absolute,
    input  logic                                set_link,
    input  logic                                conditional,
    input  logic                                test_halfword,
    input  logic                                branch_if_zero,
    input  logic [0:odd_pipe_pkg::I16_BITS-1]   i16,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]  rc,
    input  logic [0:odd_pipe_pkg::WORD_BITS-1]  pc,
    output logic [0:odd_pipe_pkg::WORD_BITS-1]  pc_out,
    output logic [0:odd_pipe_pkg::QUAD_BITS-1]  value,
    output logic                                write_enable
);
    logic [0:odd_pipe_pkg::WORD_BITS-1] ls_mask;
    logic [0:odd_pipe_pkg::WORD_BITS-1] offset;
    logic [0:odd_pipe_pkg::WORD_BITS-1] target;
    logic [0:odd_pipe_pkg::WORD_BITS-1] next_pc;
    logic                               rc_zero;
    logic                               taken;

    assign ls_mask = (32'd1 << LS_ADDR_BITS) - 32'd1;

    // word offset from the sign-extended immediate
    assign offset = {{(odd_pipe_pkg::WORD_BITS - odd_pipe_pkg::I16_BITS - 2){i16[0]}},
        i16, 2'b00};
    assign target  = (absolute ? offset : pc + offset) & ls_mask;
    assign next_pc = (pc + 32'd4) & ls_mask;

    // the tested register is rc, word 0 or its low halfword
    assign rc_zero = test_halfword ?
        (rc[odd_pipe_pkg::WORD_BITS - odd_pipe_pkg::HALFWORD_BITS:odd_pipe_pkg::WORD_BITS-1]
            == '0) :
        (rc[0:odd_pipe_pkg::WORD_BITS-1] == '0);
    assign taken = !conditional || (rc_zero == branch_if_zero);

    always_comb
    begin
        if (branch_sel && taken)
        begin
            pc_out = conditional ? (target & 32'hFFFF_FFFC) : target;
        end
        else if (branch_sel || permute_sel)
        begin
            pc_out = next_pc;
        end
        else
        begin
            // nop
            pc_out = '0;
        end
    end

    // link value sits in word 0
    assign write_enable = branch_sel && set_link;
    assign value = write_enable ?
        {next_pc, {(odd_pipe_pkg::QUAD_BITS - odd_pipe_pkg::WORD_BITS){1'b0}}} : '0;

endmodule

// ==== hw/odd_issue_stage.sv ====
module odd_issue_stage (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [0:odd_pipe_pkg::OPCODE_BITS-1]     opcode,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]       ra,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]       rb,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]       rc,
    input  logic [0:odd_pipe_pkg::RT_ADDR_BITS-1]    rt_addr,
    input  logic [0:odd_pipe_pkg::I7_BITS-1]         i7,
    input  logic [0:odd_pipe_pkg::I16_BITS-1]        i16,
    input  logic [0:odd_pipe_pkg::WORD_BITS-1]       pc_in,
    output logic [0:odd_pipe_pkg::QUAD_BITS-1]       ra_q,
    output logic [0:odd_pipe_pkg::QUAD_BITS-1]       rc_q,
    output logic [0:odd_pipe_pkg::I16_BITS-1]        i16_q,
    output logic [0:odd_pipe_pkg::WORD_BITS-1]       pc_q,
    output logic [0:odd_pipe_pkg::RT_ADDR_BITS-1]    rt_addr_q,
    output logic [0:odd_pipe_pkg::SHIFT_BITS-1]      shift_amount,
    output logic                                     byte_granular,
    output logic                                     rotate,
    output logic [0:odd_pipe_pkg::GATHER_BITS-1]     gather_size,
    output logic                                     permute_sel,
    output logic                                     branch_sel,
    output logic                                     absolute,
    output logic                                     set_link,
    output logic                                     conditional,
    output logic                                     test_halfword,
    output logic                                     branch_if_zero
);
    logic [0:odd_pipe_pkg::OPCODE_BITS-1] opcode_q;
    logic [0:odd_pipe_pkg::QUAD_BITS-1]   rb_q;
    logic [0:odd_pipe_pkg::I7_BITS-1]     i7_q;

    // a reset issue slot holds a nop with zero operands
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            opcode_q  <= odd_pipe_pkg::OP_NOP;
            ra_q      <= '0;
            rb_q      <= '0;
            rc_q      <= '0;
            rt_addr_q <= '0;
            i7_q      <= '0;
            i16_q     <= '0;
            pc_q      <= '0;
        end
        else
        begin
            opcode_q  <= opcode;
            ra_q      <= ra;
            rb_q      <= rb;
            rc_q      <= rc;
            rt_addr_q <= rt_addr;
            i7_q      <= i7;
            i16_q     <= i16;
            pc_q      <= pc_in;
        end
    end

    always_comb
    begin
        shift_amount   = '0;
        byte_granular  = 1'b0;
        rotate         = 1'b0;
        gather_size    = odd_pipe_pkg::GATHER_NONE;
        permute_sel    = 1'b1;
        branch_sel     = 1'b0;
        absolute       = 1'b0;
        set_link       = 1'b0;
        conditional    = 1'b0;
        test_halfword  = 1'b0;
        branch_if_zero = 1'b0;
        case (opcode_q)
            odd_pipe_pkg::OP_SHLQBI:
                shift_amount = {2'b00, rb_q[29:31]};
            odd_pipe_pkg::OP_SHLQBII:
                shift_amount = {2'b00, i7_q[4:6]};
            odd_pipe_pkg::OP_ROTQBI:
            begin
                shift_amount = {2'b00, rb_q[29:31]};
                rotate       = 1'b1;
            end
            odd_pipe_pkg::OP_ROTQBII:
            begin
                shift_amount = {2'b00, i7_q[4:6]};
                rotate       = 1'b1;
            end
            odd_pipe_pkg::OP_SHLQBY:
            begin
                shift_amount  = rb_q[27:31];
                byte_granular = 1'b1;
            end
            odd_pipe_pkg::OP_SHLQBYI:
            begin
                shift_amount  = i7_q[2:6];
                byte_granular = 1'b1;
            end
            odd_pipe_pkg::OP_SHLQBYBI:
            begin
                shift_amount  = rb_q[24:28];
                byte_granular = 1'b1;
            end
            // byte rotates only ever see a count below 16
            odd_pipe_pkg::OP_ROTQBY:
            begin
                shift_amount  = {1'b0, rb_q[28:31]};
                byte_granular = 1'b1;
                rotate        = 1'b1;
            end
            odd_pipe_pkg::OP_ROTQBYI:
            begin
                shift_amount  = {1'b0, i7_q[3:6]};
                byte_granular = 1'b1;
                rotate        = 1'b1;
            end
            odd_pipe_pkg::OP_ROTQBYBI:
            begin
                shift_amount  = {1'b0, rb_q[25:28]};
                byte_granular = 1'b1;
                rotate        = 1'b1;
            end
            odd_pipe_pkg::OP_GBB:
                gather_size = odd_pipe_pkg::GATHER_BYTE;
            odd_pipe_pkg::OP_GBH:
                gather_size = odd_pipe_pkg::GATHER_HALF;
            odd_pipe_pkg::OP_GB:
                gather_size = odd_pipe_pkg::GATHER_WORD;
            default:
            begin
                permute_sel = 1'b0;
                branch_sel  = opcode_q inside {odd_pipe_pkg::OP_BR, odd_pipe_pkg::OP_BRA,
                    odd_pipe_pkg::OP_BRSL, odd_pipe_pkg::OP_BRASL, odd_pipe_pkg::OP_BRNZ,
                    odd_pipe_pkg::OP_BRZ, odd_pipe_pkg::OP_BRHNZ, odd_pipe_pkg::OP_BRHZ};
                absolute    = opcode_q inside {odd_pipe_pkg::OP_BRA, odd_pipe_pkg::OP_BRASL};
                set_link    = opcode_q inside {odd_pipe_pkg::OP_BRSL, odd_pipe_pkg::OP_BRASL};
                conditional = opcode_q inside {odd_pipe_pkg::OP_BRNZ, odd_pipe_pkg::OP_BRZ,
                    odd_pipe_pkg::OP_BRHNZ, odd_pipe_pkg::OP_BRHZ};
                test_halfword  = opcode_q inside {odd_pipe_pkg::OP_BRHNZ, odd_pipe_pkg::OP_BRHZ};
                branch_if_zero = opcode_q inside {odd_pipe_pkg::OP_BRZ, odd_pipe_pkg::OP_BRHZ};
            end
        endcase
    end

endmodule

// ==== hw/odd_pipe.sv ====
module odd_pipe #(
    parameter int LS_ADDR_BITS  = 18,
    parameter int FORWARD_DEPTH = 7
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [0:odd_pipe_pkg::OPCODE_BITS-1]   opcode,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]     ra,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]     rb,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]     rc,
    input  logic [0:odd_pipe_pkg::RT_ADDR_BITS-1]  rt_addr,
    input  logic [0:odd_pipe_pkg::I7_BITS-1]       i7,
    input  logic [0:odd_pipe_pkg::I16_BITS-1]      i16,
    input  logic [0:odd_pipe_pkg::WORD_BITS-1]     pc_in,
    output logic [0:odd_pipe_pkg::WORD_BITS-1]     pc_out,
    output logic [1:FORWARD_DEPTH][0:odd_pipe_pkg::PACKET_BITS-1] fw_stages,
    output logic [0:odd_pipe_pkg::PACKET_BITS-1]   out_packet
);
    logic [0:odd_pipe_pkg::QUAD_BITS-1]    ra_q;
    logic [0:odd_pipe_pkg::QUAD_BITS-1]    rc_q;
    logic [0:odd_pipe_pkg::I16_BITS-1]     i16_q;
    logic [0:odd_pipe_pkg::WORD_BITS-1]    pc_q;
    logic [0:odd_pipe_pkg::RT_ADDR_BITS-1] rt_addr_q;
    logic [0:odd_pipe_pkg::SHIFT_BITS-1]   shift_amount;
    logic [0:odd_pipe_pkg::GATHER_BITS-1]  gather_size;
    logic                                  byte_granular;
    logic                                  rotate;
    logic                                  permute_sel;
    logic                                  branch_sel;
    logic                                  absolute;
    logic                                  set_link;
    logic                                  conditional;
    logic                                  test_halfword;
    logic                                  branch_if_zero;
    logic [0:odd_pipe_pkg::QUAD_BITS-1]    permute_value;
    logic [0:odd_pipe_pkg::QUAD_BITS-1]    branch_value;
    logic                                  branch_write_enable;

    odd_issue_stage issue (
        .clock, .reset, .opcode, .ra, .rb, .rc, .rt_addr, .i7, .i16, .pc_in,
        .ra_q, .rc_q, .i16_q, .pc_q, .rt_addr_q, .shift_amount, .byte_granular,
        .rotate, .gather_size, .permute_sel, .branch_sel, .absolute, .set_link,
        .conditional, .test_halfword, .branch_if_zero
    );

    permute_unit permute (
        .ra(ra_q), .shift_amount, .byte_granular, .rotate, .gather_size,
        .value(permute_value)
    );

    branch_unit #(
        .LS_ADDR_BITS(LS_ADDR_BITS)
    ) branch (
        .branch_sel, .permute_sel, .absolute, .set_link, .conditional, .test_halfword,
        .branch_if_zero, .i16(i16_q), .rc(rc_q), .pc(pc_q), .pc_out,
        .value(branch_value), .write_enable(branch_write_enable)
    );

    result_forward_pipe #(
        .FORWARD_DEPTH(FORWARD_DEPTH)
    ) forward (
        .clock, .reset, .permute_sel, .branch_sel, .permute_value, .branch_value,
        .branch_write_enable, .rt_addr(rt_addr_q), .fw_stages, .out_packet
    );

endmodule

// ==== hw/odd_pipe_pkg.sv ====
package odd_pipe_pkg;

    // operand and field widths
    localparam int QUAD_BITS     = 128;
    localparam int WORD_BITS     = 32;
    localparam int HALFWORD_BITS = 16;
    localparam int BYTE_BITS     = 8;
    localparam int OPCODE_BITS   = 11;
    localparam int RT_ADDR_BITS  = 7;
    localparam int I7_BITS       = 7;
    localparam int I16_BITS      = 16;
    localparam int UNIT_ID_BITS  = 3;
    localparam int LATENCY_BITS  = 4;

    // shift count is at most 31 bytes
    localparam int SHIFT_BITS  = 5;
    localparam int GATHER_BITS = 2;

    // packet layout from bit 0: unit id, value, write enable, rt address, latency
    localparam int PKT_UID_POS   = 0;
    localparam int PKT_VALUE_POS = PKT_UID_POS + UNIT_ID_BITS;
    localparam int PKT_WE_POS    = PKT_VALUE_POS + QUAD_BITS;
    localparam int PKT_RT_POS    = PKT_WE_POS + 1;
    localparam int PKT_LAT_POS   = PKT_RT_POS + RT_ADDR_BITS;
    localparam int PACKET_BITS   = PKT_LAT_POS + LATENCY_BITS;

    // permute group
    localparam logic [0:OPCODE_BITS-1] OP_SHLQBI   = 11'h1DB;
    localparam logic [0:OPCODE_BITS-1] OP_SHLQBII  = 11'h1FB;
    localparam logic [0:OPCODE_BITS-1] OP_SHLQBY   = 11'h1DF;
    localparam logic [0:OPCODE_BITS-1] OP_SHLQBYI  = 11'h1FF;
    localparam logic [0:OPCODE_BITS-1] OP_SHLQBYBI = 11'h1CF;
    localparam logic [0:OPCODE_BITS-1] OP_ROTQBY   = 11'h1DC;
    localparam logic [0:OPCODE_BITS-1] OP_ROTQBYI  = 11'h1FC;
    localparam logic [0:OPCODE_BITS-1] OP_ROTQBYBI = 11'h1CC;
    localparam logic [0:OPCODE_BITS-1] OP_ROTQBI   = 11'h1D8;
    localparam logic [0:OPCODE_BITS-1] OP_ROTQBII  = 11'h1F8;
    localparam logic [0:OPCODE_BITS-1] OP_GBB      = 11'h1B2;
    localparam logic [0:OPCODE_BITS-1] OP_GBH      = 11'h1B1;
    localparam logic [0:OPCODE_BITS-1] OP_GB       = 11'h1B0;

    // branch group, 9-bit opcodes padded with two zero bits
    localparam logic [0:OPCODE_BITS-1] OP_BR    = 11'h190;
    localparam logic [0:OPCODE_BITS-1] OP_BRA   = 11'h180;
    localparam logic [0:OPCODE_BITS-1] OP_BRSL  = 11'h198;
    localparam logic [0:OPCODE_BITS-1] OP_BRASL = 11'h188;
    localparam logic [0:OPCODE_BITS-1] OP_BRNZ  = 11'h108;
    localparam logic [0:OPCODE_BITS-1] OP_BRZ   = 11'h100;
    localparam logic [0:OPCODE_BITS-1] OP_BRHNZ = 11'h118;
    localparam logic [0:OPCODE_BITS-1] OP_BRHZ  = 11'h110;
    localparam logic [0:OPCODE_BITS-1] OP_NOP   = 11'h000;

    // gather element size codes
    localparam logic [0:GATHER_BITS-1] GATHER_NONE = 2'd0;
    localparam logic [0:GATHER_BITS-1] GATHER_BYTE = 2'd1;
    localparam logic [0:GATHER_BITS-1] GATHER_HALF = 2'd2;
    localparam logic [0:GATHER_BITS-1] GATHER_WORD = 2'd3;

    localparam logic [0:UNIT_ID_BITS-1] PERMUTE_UNIT_ID = 3'd5;
    localparam logic [0:UNIT_ID_BITS-1] BRANCH_UNIT_ID  = 3'd7;
    localparam logic [0:LATENCY_BITS-1] PERMUTE_LATENCY = 4'd4;
    localparam logic [0:LATENCY_BITS-1] BRANCH_LATENCY  = 4'd1;

endpackage

// ==== hw/permute_unit.sv ====
module permute_unit (
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]   ra,
    input  logic [0:odd_pipe_pkg::SHIFT_BITS-1]  shift_amount,
    input  logic                                 byte_granular,
    input  logic                                 rotate,
    input  logic [0:odd_pipe_pkg::GATHER_BITS-1] gather_size,
    output logic [0:odd_pipe_pkg::QUAD_BITS-1]   value
);
    // up to 31 bytes gives 248 bits
    logic [7:0]                          bit_count;
    logic [0:odd_pipe_pkg::QUAD_BITS-1]  shifted;
    logic [0:odd_pipe_pkg::QUAD_BITS-1]  wrapped;
    logic [0:odd_pipe_pkg::WORD_BITS-1]  gathered;

    assign bit_count = byte_granular ? {shift_amount, 3'b000} : {3'b000, shift_amount};

    // bit 0 is the msb so a left shift moves data toward index 0
    // counts of 128 bits or more leave nothing behind
    assign shifted = ra << bit_count;

    // bits pushed out of the top come back in at the bottom
    assign wrapped = ra >> (odd_pipe_pkg::QUAD_BITS - bit_count);

    // lsb of each element, element 0 lands on the msb of the right-aligned field
    always_comb
    begin
        gathered = '0;
        case (gather_size)
            odd_pipe_pkg::GATHER_BYTE:
                for (int j = 0; j < 16; j++)
                begin
                    gathered[16 + j] = ra[j * odd_pipe_pkg::BYTE_BITS
                        + odd_pipe_pkg::BYTE_BITS - 1];
                end
            odd_pipe_pkg::GATHER_HALF:
                for (int j = 0; j < 8; j++)
                begin
                    gathered[24 + j] = ra[j * odd_pipe_pkg::HALFWORD_BITS
                        + odd_pipe_pkg::HALFWORD_BITS - 1];
                end
            odd_pipe_pkg::GATHER_WORD:
                for (int j = 0; j < 4; j++)
                begin
                    gathered[28 + j] = ra[j * odd_pipe_pkg::WORD_BITS
                        + odd_pipe_pkg::WORD_BITS - 1];
                end
            default:
                gathered = '0;
        endcase
    end

    always_comb
    begin
        if (gather_size != odd_pipe_pkg::GATHER_NONE)
        begin
            value = {gathered, {(odd_pipe_pkg::QUAD_BITS - odd_pipe_pkg::WORD_BITS){1'b0}}};
        end
        else if (rotate)
        begin
            value = shifted | wrapped;
        end
        else
        begin
            value = shifted;
        end
    end

endmodule

// ==== hw/result_forward_pipe.sv ====
module result_forward_pipe #(
    parameter int FORWARD_DEPTH = 7
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   permute_sel,
    input  logic                                   branch_sel,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]     permute_value,
    input  logic [0:odd_pipe_pkg::QUAD_BITS-1]     branch_value,
    input  logic                                   branch_write_enable,
    input  logic [0:odd_pipe_pkg::RT_ADDR_BITS-1]  rt_addr,
    output logic [1:FORWARD_DEPTH][0:odd_pipe_pkg::PACKET_BITS-1] fw_stages,
    output logic [0:odd_pipe_pkg::PACKET_BITS-1]   out_packet
);
    logic [0:odd_pipe_pkg::PACKET_BITS-1]                 stage1;
    logic [2:FORWARD_DEPTH][0:odd_pipe_pkg::PACKET_BITS-1] stage_q;

    // stage 1 follows the issue registers combinationally
    always_comb
    begin
        stage1 = '0;
        if (permute_sel)
        begin
            stage1[odd_pipe_pkg::PKT_UID_POS +: odd_pipe_pkg::UNIT_ID_BITS] =
                odd_pipe_pkg::PERMUTE_UNIT_ID;
            stage1[odd_pipe_pkg::PKT_VALUE_POS +: odd_pipe_pkg::QUAD_BITS] = permute_value;
            stage1[odd_pipe_pkg::PKT_WE_POS] = 1'b1;
            stage1[odd_pipe_pkg::PKT_RT_POS +: odd_pipe_pkg::RT_ADDR_BITS] = rt_addr;
            stage1[odd_pipe_pkg::PKT_LAT_POS +: odd_pipe_pkg::LATENCY_BITS] =
                odd_pipe_pkg::PERMUTE_LATENCY;
        end
        else if (branch_sel)
        begin
            stage1[odd_pipe_pkg::PKT_UID_POS +: odd_pipe_pkg::UNIT_ID_BITS] =
                odd_pipe_pkg::BRANCH_UNIT_ID;
            stage1[odd_pipe_pkg::PKT_VALUE_POS +: odd_pipe_pkg::QUAD_BITS] = branch_value;
            stage1[odd_pipe_pkg::PKT_WE_POS] = branch_write_enable;
            stage1[odd_pipe_pkg::PKT_RT_POS +: odd_pipe_pkg::RT_ADDR_BITS] = rt_addr;
            stage1[odd_pipe_pkg::PKT_LAT_POS +: odd_pipe_pkg::LATENCY_BITS] =
                odd_pipe_pkg::BRANCH_LATENCY;
        end
    end

    // the chain never stalls
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage_q    <= '0;
            out_packet <= '0;
        end
        else
        begin
            stage_q[2] <= stage1;
            for (int k = 3; k <= FORWARD_DEPTH; k++)
            begin
                stage_q[k] <= stage_q[k-1];
            end
            out_packet <= stage_q[FORWARD_DEPTH];
        end
    end

    assign fw_stages = {stage1, stage_q};

endmodule

// ==== include/odd_pipe_vectors.svh ====
`ifndef ODD_PIPE_VECTORS_SVH
`define ODD_PIPE_VECTORS_SVH

// each row gives opcode, ra, rb, rc, i7, i16, pc, rt, random ra flag,
// then expected pc_out, value, write enable, unit id and latency
localparam logic [0:127] RA_A     = 128'h00112233_44556677_8899AABB_CCDDEEFF;
localparam logic [0:127] SHL4_A   = 128'h01122334_45566778_899AABBC_CDDEEFF0;
localparam logic [0:127] SHLBY3_A = 128'h33445566_778899AA_BBCCDDEE_FF000000;
localparam logic [0:127] SHLBY2_A = 128'h22334455_66778899_AABBCCDD_EEFF0000;
localparam logic [0:127] ROTBY5_A = 128'h55667788_99AABBCC_DDEEFF00_11223344;
localparam logic [0:127] ROTBY1_A = 128'h11223344_55667788_99AABBCC_DDEEFF00;
localparam logic [0:127] ROTBY3_A = 128'h33445566_778899AA_BBCCDDEE_FF001122;
localparam logic [0:127] RA_ENDS  = 128'hF0000000_00000000_00000000_00000001;
localparam logic [0:127] RA_TOP   = 128'h80000000_00000000_00000000_00000000;
localparam logic [0:127] RA_GB    = 128'h00000001_00000000_00000003_00000002;

task automatic load_vectors();
    // shifts with a 16 byte count last
    add_row(odd_pipe_pkg::OP_SHLQBI, RA_A, w0(4), '0, 0, 0, 'h100, 1, 0, 'h104, SHL4_A, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_SHLQBII, 128'h1, '0, '0, 3, 0, 'h100, 2, 0, 'h104, 128'h8, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_SHLQBY, RA_A, w0(3), '0, 0, 0, 'h100, 3, 0, 'h104, SHLBY3_A, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_SHLQBYBI, RA_A, w0(16), '0, 0, 0, 'h100, 4, 0, 'h104, SHLBY2_A,
        1, 5, 4);
    add_row(odd_pipe_pkg::OP_SHLQBYI, RA_A, '0, '0, 16, 0, 'h100, 5, 0, 'h104, '0, 1, 5, 4);
    // rotates
    add_row(odd_pipe_pkg::OP_ROTQBY, RA_A, w0(5), '0, 0, 0, 'h100, 6, 0, 'h104, ROTBY5_A, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_ROTQBYI, RA_A, '0, '0, 1, 0, 'h100, 7, 0, 'h104, ROTBY1_A, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_ROTQBYBI, RA_A, w0('h98), '0, 0, 0, 'h100, 8, 0, 'h104, ROTBY3_A,
        1, 5, 4);
    add_row(odd_pipe_pkg::OP_ROTQBI, RA_ENDS, w0(4), '0, 0, 0, 'h100, 9, 0, 'h104, 128'h1F,
        1, 5, 4);
    add_row(odd_pipe_pkg::OP_ROTQBII, RA_TOP, '0, '0, 1, 0, 'h100, 10, 0, 'h104, 128'h1, 1, 5, 4);
    // gathers land in word 0
    add_row(odd_pipe_pkg::OP_GBB, RA_A, '0, '0, 0, 0, 'h100, 11, 0, 'h104, w0('h5555), 1, 5, 4);
    add_row(odd_pipe_pkg::OP_GBH, RA_A, '0, '0, 0, 0, 'h100, 12, 0, 'h104, w0('hFF), 1, 5, 4);
    add_row(odd_pipe_pkg::OP_GB, RA_GB, '0, '0, 0, 0, 'h100, 13, 0, 'h104, w0('hA), 1, 5, 4);
    // random ra with the value from the reference model
    add_row(odd_pipe_pkg::OP_ROTQBY, '0, w0(7), '0, 0, 0, 'h100, 14, 1, 'h104, '0, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_GBB, '0, '0, '0, 0, 0, 'h100, 15, 1, 'h104, '0, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_SHLQBI, '0, w0(5), '0, 0, 0, 'h100, 16, 1, 'h104, '0, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_ROTQBI, '0, w0(6), '0, 0, 0, 'h100, 17, 1, 'h104, '0, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_GBH, '0, '0, '0, 0, 0, 'h100, 18, 1, 'h104, '0, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_ROTQBYI, '0, '0, '0, 9, 0, 'h100, 19, 1, 'h104, '0, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_ROTQBYBI, '0, w0('hA8), '0, 0, 0, 'h100, 36, 1, 'h104, '0, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_ROTQBII, '0, '0, '0, 6, 0, 'h100, 37, 1, 'h104, '0, 1, 5, 4);
    add_row(odd_pipe_pkg::OP_GB, '0, '0, '0, 0, 0, 'h100, 38, 1, 'h104, '0, 1, 5, 4);
    // unconditional branches
    add_row(odd_pipe_pkg::OP_BR, '0, '0, '0, 0, 'h0010, 'h1000, 20, 0, 'h1040, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BR, '0, '0, '0, 0, 'hFFF0, 'h1000, 21, 0, 'h0FC0, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BR, '0, '0, '0, 0, 'h0008, 'h3FFF0, 22, 0, 'h0010, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRA, '0, '0, '0, 0, 'h0100, 'h1000, 23, 0, 'h0400, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRA, '0, '0, '0, 0, 'h8000, 'h1000, 24, 0, 'h20000, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRSL, '0, '0, '0, 0, 'h0004, 'h2000, 25, 0, 'h2010, w0('h2004),
        1, 7, 1);
    add_row(odd_pipe_pkg::OP_BRASL, '0, '0, '0, 0, 'h0020, 'h3000, 26, 0, 'h0080, w0('h3004),
        1, 7, 1);
    // conditional branches taken then not taken
    add_row(odd_pipe_pkg::OP_BRZ, '0, '0, '0, 0, 9, 'h502, 27, 0, 'h524, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRZ, '0, '0, w0(1), 0, 9, 'h502, 28, 0, 'h506, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRNZ, '0, '0, w0('h10), 0, 9, 'h502, 29, 0, 'h524, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRNZ, '0, '0, '0, 0, 9, 'h502, 30, 0, 'h506, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRHZ, '0, '0, w0('hFFFF0000), 0, 9, 'h502, 31, 0, 'h524, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRHZ, '0, '0, w0(1), 0, 9, 'h502, 32, 0, 'h506, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRHNZ, '0, '0, w0('h8000), 0, 9, 'h502, 33, 0, 'h524, '0, 0, 7, 1);
    add_row(odd_pipe_pkg::OP_BRHNZ, '0, '0, w0('h10000), 0, 9, 'h502, 34, 0, 'h506, '0, 0, 7, 1);
    // nop gives an all zero packet
    add_row(odd_pipe_pkg::OP_NOP, RA_A, '0, '0, 0, 0, 'h700, 35, 0, 'h0, '0, 0, 0, 0);
endtask

`endif

// ==== verification/odd_pipe_tb.sv ====
module odd_pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                clock;
    logic                reset;
    logic [0:10]         opcode;
    logic [0:127]        ra;
    logic [0:127]        rb;
    logic [0:127]        rc;
    logic [0:6]          rt_addr;
    logic [0:6]          i7;
    logic [0:15]         i16;
    logic [0:31]         pc_in;
    logic [0:31]         pc_out;
    logic [1:7][0:142]   fw_stages;
    logic [0:142]        out_packet;

    // table columns
    logic [0:10]  t_op[$];
    logic [0:127] t_ra[$];
    logic [0:127] t_rb[$];
    logic [0:127] t_rc[$];
    logic [0:6]   t_i7[$];
    logic [0:15]  t_i16[$];
    logic [0:31]  t_pc[$];
    logic [0:6]   t_rt[$];
    logic [0:31]  t_pc_exp[$];
    logic [0:142] t_pkt[$];
    int           row_err[$];

    // packets in flight
    logic [0:142] pend_pkt[$];
    int           pend_issue[$];
    int           pend_row[$];

    int cycle_count = 0;
    int cycle_limit = 1000;
    int check_errors = 0;
    int rows_passed = 0;
    int rows_failed = 0;

    odd_pipe uut (
        .clock, .reset, .opcode, .ra, .rb, .rc, .rt_addr, .i7, .i16, .pc_in,
        .pc_out, .fw_stages, .out_packet
    );

    function automatic logic [0:127] w0(input logic [0:31] x);
        return {x, 96'h0};
    endfunction

    // permute behavior written from the instruction rules
    function automatic logic [0:127] ref_permute(input logic [0:10] op, input logic [0:127] a,
        input logic [0:127] b, input logic [0:6] imm);
        logic [0:127] res;
        int n;
        int e;
        int cnt;
        bit rot;
        res = '0;
        n = 0;
        e = 0;
        case (op)
            odd_pipe_pkg::OP_SHLQBI: n = b[29:31];
            odd_pipe_pkg::OP_SHLQBII: n = imm[4:6];
            odd_pipe_pkg::OP_SHLQBY: n = 8 * b[27:31];
            odd_pipe_pkg::OP_SHLQBYI: n = 8 * imm[2:6];
            odd_pipe_pkg::OP_SHLQBYBI: n = 8 * b[24:28];
            odd_pipe_pkg::OP_ROTQBI: n = b[29:31];
            odd_pipe_pkg::OP_ROTQBII: n = imm[4:6];
            odd_pipe_pkg::OP_ROTQBY: n = 8 * b[28:31];
            odd_pipe_pkg::OP_ROTQBYI: n = 8 * imm[3:6];
            odd_pipe_pkg::OP_ROTQBYBI: n = 8 * b[25:28];
            odd_pipe_pkg::OP_GBB: e = 8;
            odd_pipe_pkg::OP_GBH: e = 16;
            odd_pipe_pkg::OP_GB: e = 32;
            default: n = 0;
        endcase
        rot = op inside {odd_pipe_pkg::OP_ROTQBI, odd_pipe_pkg::OP_ROTQBII,
            odd_pipe_pkg::OP_ROTQBY, odd_pipe_pkg::OP_ROTQBYI, odd_pipe_pkg::OP_ROTQBYBI};
        if (e != 0)
        begin
            cnt = 128 / e;
            for (int j = 0; j < cnt; j++)
                res[32 - cnt + j] = a[j * e + e - 1];
        end
        else
        begin
            for (int i = 0; i < 128; i++)
            begin
                if (i + n < 128)
                    res[i] = a[i + n];
                else if (rot)
                    res[i] = a[(i + n) % 128];
            end
        end
        return res;
    endfunction

    function automatic logic [0:142] make_packet(input logic [0:2] uid, input logic [0:127] val,
        input bit we, input logic [0:6] rt, input logic [0:3] lat);
        if (uid == 0)
            return '0;
        return {uid, val, we, rt, lat};
    endfunction

    task automatic add_row(input logic [0:10] op, input logic [0:127] a, input logic [0:127] b,
        input logic [0:127] c, input logic [0:6] imm7, input logic [0:15] imm16,
        input logic [0:31] pc, input logic [0:6] rt, input bit rnd, input logic [0:31] pc_exp,
        input logic [0:127] val, input bit we, input logic [0:2] uid, input logic [0:3] lat);
        if (rnd)
        begin
            a = {$urandom, $urandom, $urandom, $urandom};
            val = ref_permute(op, a, b, imm7);
        end
        t_op.push_back(op);
        t_ra.push_back(a);
        t_rb.push_back(b);
        t_rc.push_back(c);
        t_i7.push_back(imm7);
        t_i16.push_back(imm16);
        t_pc.push_back(pc);
        t_rt.push_back(rt);
        t_pc_exp.push_back(pc_exp);
        t_pkt.push_back(make_packet(uid, val, we, rt, lat));
        row_err.push_back(0);
    endtask

    `include "odd_pipe_vectors.svh"

    task automatic check_value(input string name, input logic [0:142] actual,
        input logic [0:142] expected, input int row);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s actual %h expected %h", $time, name, actual, expected);
            check_errors++;
            if (row >= 0)
                row_err[row]++;
        end
    endtask

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // follows each packet down the chain and checks it at out_packet
    always @(posedge clock)
    begin
        #1;
        for (int i = 0; i < pend_pkt.size(); i++)
        begin
            if (cycle_count - pend_issue[i] >= 1 && cycle_count - pend_issue[i] <= 6)
                check_value($sformatf("fw_stages[%0d]", cycle_count - pend_issue[i] + 1),
                    fw_stages[cycle_count - pend_issue[i] + 1], pend_pkt[i], pend_row[i]);
        end
        if (pend_pkt.size() != 0 && cycle_count - pend_issue[0] == 7)
        begin
            check_value("out_packet", out_packet, pend_pkt[0], pend_row[0]);
            $display("row %0d opcode %h: %s", pend_row[0], t_op[pend_row[0]],
                row_err[pend_row[0]] == 0 ? "ok" : "mismatch");
            if (row_err[pend_row[0]] == 0)
                rows_passed++;
            else
                rows_failed++;
            void'(pend_pkt.pop_front());
            void'(pend_issue.pop_front());
            void'(pend_row.pop_front());
        end
    end

    initial
    begin
        void'($urandom(56));
        reset = 1'b1;
        opcode = odd_pipe_pkg::OP_NOP;
        ra = '0;
        rb = '0;
        rc = '0;
        rt_addr = '0;
        i7 = '0;
        i16 = '0;
        pc_in = '0;
        load_vectors();
        cycle_limit = (t_op.size() + 10) * 2;
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;

        check_value("pc_out", pc_out, '0, -1);
        check_value("out_packet", out_packet, '0, -1);
        for (int k = 1; k <= 7; k++)
            check_value($sformatf("fw_stages[%0d]", k), fw_stages[k], '0, -1);

        // one instruction per cycle
        for (int r = 0; r < t_op.size(); r++)
        begin
            opcode = t_op[r];
            ra = t_ra[r];
            rb = t_rb[r];
            rc = t_rc[r];
            i7 = t_i7[r];
            i16 = t_i16[r];
            pc_in = t_pc[r];
            rt_addr = t_rt[r];
            @(posedge clock);
            #1;
            check_value("pc_out", pc_out, t_pc_exp[r], r);
            check_value("fw_stages[1]", fw_stages[1], t_pkt[r], r);
            pend_pkt.push_back(t_pkt[r]);
            pend_issue.push_back(cycle_count);
            pend_row.push_back(r);
        end
        opcode = odd_pipe_pkg::OP_NOP;
        while (pend_pkt.size() != 0)
            @(posedge clock);

        $display("rows passed %0d, rows failed %0d, check errors %0d",
            rows_passed, rows_failed, check_errors);
        if (check_errors == 0 && rows_failed == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
